// ==== Makefile ====
# Modbus RTU slave simulation with Verilator

TOP = tb_modbus_slave

all: run

build:
	verilator --binary --timing --assert -f verilog.f --top-module $(TOP) -o $(TOP)

run: build
	./obj_dir/$(TOP) | tee sim.log
	grep -q "^STATUS: PASS$$" sim.log

lint:
	verilator --lint-only -Wall --timing -f verilog.f --top-module modbus_slave_top

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean

// ==== include/mb_macros.svh ====
// Modbus RTU slave sizes and protocol constants
// Shared by the collector, executor, sender and register file

`ifndef MB_MACROS_SVH
`define MB_MACROS_SVH

// Holding register file depth
`define MB_REG_WORDS 64

// Coil image width
`define MB_COILS 32

// Receive and transmit buffer depth in bytes
`define MB_BUF_BYTES 256

// CRC-16 start value and reflected polynomial
`define MB_CRC_INIT 16'hFFFF
`define MB_CRC_POLY 16'hA001

// Shortest frame: address, function and two CRC bytes
`define MB_MIN_FRAME 4

`endif

// ==== src/crc16_modbus.sv ====
// Modbus CRC-16 accumulator
// Folds one byte per valid cycle, eight reflected shift/XOR steps unrolled

`default_nettype none
`timescale 1ns/1ns

`include "mb_macros.svh"

module crc16_modbus (
  input  logic             clk,
  input  logic             rst,
  input  logic             clr,
  input  mb_pkg::mb_byte_t data_in,
  input  logic             data_valid,
  output mb_pkg::mb_word_t crc
);

  mb_pkg::mb_word_t crc_next;

  // Reflected CRC, LSB of the byte enters first
  always_comb begin
    crc_next = crc ^ {8'h00, data_in};
    for (int i = 0; i < 8; i++) begin
      if (crc_next[0]) begin
        crc_next = (crc_next >> 1) ^ `MB_CRC_POLY;
      end else begin
        crc_next = crc_next >> 1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst || clr) begin
      crc <= `MB_CRC_INIT;
    end else if (data_valid) begin
      crc <= crc_next;
    end
  end

endmodule

`default_nettype wire

// ==== src/frame_collector.sv ====
// Receive frame collector
// Buffers one frame between the bridge's frame marks and checks its CRC.
// The frame is held for the executor until the slave is no longer busy

`default_nettype none
`timescale 1ns/1ns

`include "mb_macros.svh"

module frame_collector (
  input  logic             clk,
  input  logic             rst,
  input  logic             frame_start,
  input  logic             frame_end,
  input  logic             rx_b_v,
  input  mb_pkg::mb_byte_t rx_b,
  input  logic             busy,
  input  mb_pkg::mb_idx_t  rd_idx,
  output mb_pkg::mb_byte_t rd_byte,
  output mb_pkg::mb_idx_t  frame_len,
  output logic             frame_ok,
  output logic             crc_err
);

  typedef enum logic [1:0] {S_IDLE, S_COLLECT, S_CHECK} state_t;

  state_t           state;
  mb_pkg::mb_byte_t buf_mem [`MB_BUF_BYTES];
  mb_pkg::mb_word_t crc;
  logic             start_ok;
  logic             byte_in;

  assign start_ok = frame_start && !busy && (state == S_IDLE);
  assign byte_in  = rx_b_v && (state == S_COLLECT);

  // Runs over the CRC bytes too, so a good frame ends at zero
  crc16_modbus u_crc (
    .clk        (clk),
    .rst        (rst),
    .clr        (start_ok),
    .data_in    (rx_b),
    .data_valid (byte_in),
    .crc        (crc)
  );

  // Frame storage, registered read port for the executor
  always_ff @(posedge clk) begin
    if (byte_in) begin
      buf_mem[frame_len] <= rx_b;
    end
    rd_byte <= buf_mem[rd_idx];
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= S_IDLE;
      frame_len <= '0;
      frame_ok  <= 1'b0;
      crc_err   <= 1'b0;
    end else begin
      frame_ok <= 1'b0;
      crc_err  <= 1'b0;
      case (state)
        S_IDLE: begin
          if (start_ok) begin
            frame_len <= '0;
            state     <= S_COLLECT;
          end
        end
        S_COLLECT: begin
          // Count saturates, so overlong frames keep rewriting the last slot
          if (byte_in && frame_len != 8'hFF) begin
            frame_len <= frame_len + 8'd1;
          end
          if (frame_end) begin
            if (frame_len >= `MB_MIN_FRAME && crc == 16'h0000) begin
              frame_ok <= 1'b1;
              state    <= S_CHECK;
            end else begin
              crc_err <= 1'b1;
              state   <= S_IDLE;
            end
          end
        end
        default: begin
          // Hold the frame until the executor has finished with it
          if (!busy && !frame_ok) begin
            state <= S_IDLE;
          end
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== src/holding_regs.sv ====
// Holding register file
// 64 words of 16 bits, one write port and one registered read port

`default_nettype none
`timescale 1ns/1ns

`include "mb_macros.svh"

module holding_regs (
  input  logic                               clk,
  input  logic                               reg_re,
  input  logic [$clog2(`MB_REG_WORDS)-1:0]   reg_raddr,
  input  logic [$clog2(`MB_REG_WORDS)-1:0]   reg_waddr,
  input  logic                               reg_we,
  input  mb_pkg::mb_word_t                   reg_wdata,
  output mb_pkg::mb_word_t                   reg_rdata
);

  mb_pkg::mb_word_t mem [`MB_REG_WORDS];

  always_ff @(posedge clk) begin
    if (reg_we) begin
      mem[reg_waddr] <= reg_wdata;
    end
  end

  // Read data holds until the next read strobe
  always_ff @(posedge clk) begin
    if (reg_re) begin
      reg_rdata <= mem[reg_raddr];
    end
  end

endmodule

`default_nettype wire

// ==== src/mb_pkg.sv ====
// Modbus RTU slave shared types
// Frame bytes, 16-bit fields, buffer indices and supported function codes

`default_nettype none

package mb_pkg;

  // One byte of a frame
  typedef logic [7:0] mb_byte_t;

  // Register value, address or quantity field
  typedef logic [15:0] mb_word_t;

  // Index into a 256-byte frame buffer
  typedef logic [7:0] mb_idx_t;

  // Function codes handled by the slave
  typedef enum logic [7:0] {
    FC_READ_COILS  = 8'h01,
    FC_READ_HOLD   = 8'h03,
    FC_WRITE_COIL  = 8'h05,
    FC_WRITE_REG   = 8'h06,
    FC_WRITE_MULTI = 8'h10
  } mb_func_e;

endpackage

`default_nettype wire

// ==== src/modbus_slave_top.sv ====
// Modbus RTU slave top level
// Collector, executor, register file and sender, plus the sticky CRC status

`default_nettype none
`timescale 1ns/1ns

`include "mb_macros.svh"

module modbus_slave_top (
  input  logic                 clk,
  input  logic                 rst,
  input  mb_pkg::mb_word_t     cfg_map_base,
  input  logic                 frame_start,
  input  logic                 frame_end,
  input  mb_pkg::mb_byte_t     rx_b,
  input  logic                 rx_b_v,
  output mb_pkg::mb_byte_t     tx_b,
  output logic                 tx_b_v,
  input  logic                 tx_b_rdy,
  output logic [`MB_COILS-1:0] do_wdata,
  output logic [`MB_COILS-1:0] do_wmask,
  output logic                 do_we,
  output logic                 stat_crc_err
);

  mb_pkg::mb_idx_t                  rd_idx;
  mb_pkg::mb_byte_t                 rd_byte;
  mb_pkg::mb_idx_t                  frame_len;
  logic                             frame_ok;
  logic                             crc_err;
  logic                             busy;
  logic                             reg_re;
  logic                             reg_we;
  logic [$clog2(`MB_REG_WORDS)-1:0] reg_raddr;
  logic [$clog2(`MB_REG_WORDS)-1:0] reg_waddr;
  mb_pkg::mb_word_t                 reg_rdata;
  mb_pkg::mb_word_t                 reg_wdata;
  logic                             body_we;
  mb_pkg::mb_idx_t                  body_idx;
  mb_pkg::mb_byte_t                 body_byte;
  mb_pkg::mb_idx_t                  body_len;
  logic                             send_start;
  logic                             send_done;

  frame_collector u_collector (
    .clk         (clk),
    .rst         (rst),
    .frame_start (frame_start),
    .frame_end   (frame_end),
    .rx_b_v      (rx_b_v),
    .rx_b        (rx_b),
    .busy        (busy),
    .rd_idx      (rd_idx),
    .rd_byte     (rd_byte),
    .frame_len   (frame_len),
    .frame_ok    (frame_ok),
    .crc_err     (crc_err)
  );

  request_executor u_executor (
    .clk          (clk),
    .rst          (rst),
    .frame_ok     (frame_ok),
    .frame_len    (frame_len),
    .cfg_map_base (cfg_map_base),
    .rd_idx       (rd_idx),
    .rd_byte      (rd_byte),
    .reg_re       (reg_re),
    .reg_raddr    (reg_raddr),
    .reg_rdata    (reg_rdata),
    .reg_we       (reg_we),
    .reg_waddr    (reg_waddr),
    .reg_wdata    (reg_wdata),
    .do_wdata     (do_wdata),
    .do_wmask     (do_wmask),
    .do_we        (do_we),
    .body_we      (body_we),
    .body_idx     (body_idx),
    .body_byte    (body_byte),
    .body_len     (body_len),
    .send_start   (send_start),
    .send_done    (send_done),
    .busy         (busy)
  );

  holding_regs u_regs (
    .clk       (clk),
    .reg_re    (reg_re),
    .reg_raddr (reg_raddr),
    .reg_waddr (reg_waddr),
    .reg_we    (reg_we),
    .reg_wdata (reg_wdata),
    .reg_rdata (reg_rdata)
  );

  response_sender u_sender (
    .clk        (clk),
    .rst        (rst),
    .body_we    (body_we),
    .body_idx   (body_idx),
    .body_byte  (body_byte),
    .body_len   (body_len),
    .send_start (send_start),
    .tx_b       (tx_b),
    .tx_b_v     (tx_b_v),
    .tx_b_rdy   (tx_b_rdy),
    .send_done  (send_done)
  );

  // CRC error status stays set until reset
  always_ff @(posedge clk) begin
    if (rst) begin
      stat_crc_err <= 1'b0;
    end else if (crc_err) begin
      stat_crc_err <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== src/request_executor.sv ====
// Modbus request executor
// Reads the header of a good frame, performs the register or coil action
// and writes the response body for the sender

`default_nettype none
`timescale 1ns/1ns

`include "mb_macros.svh"

module request_executor (
  input  logic                               clk,
  input  logic                               rst,
  input  logic                               frame_ok,
  input  mb_pkg::mb_idx_t                    frame_len,
  input  mb_pkg::mb_word_t                   cfg_map_base,
  output mb_pkg::mb_idx_t                    rd_idx,
  input  mb_pkg::mb_byte_t                   rd_byte,
  output logic                               reg_re,
  output logic [$clog2(`MB_REG_WORDS)-1:0]   reg_raddr,
  input  mb_pkg::mb_word_t                   reg_rdata,
  output logic                               reg_we,
  output logic [$clog2(`MB_REG_WORDS)-1:0]   reg_waddr,
  output mb_pkg::mb_word_t                   reg_wdata,
  output logic [`MB_COILS-1:0]               do_wdata,
  output logic [`MB_COILS-1:0]               do_wmask,
  output logic                               do_we,
  output logic                               body_we,
  output mb_pkg::mb_idx_t                    body_idx,
  output mb_pkg::mb_byte_t                   body_byte,
  output mb_pkg::mb_idx_t                    body_len,
  output logic                               send_start,
  input  logic                               send_done,
  output logic                               busy
);

  localparam int RA_W = $clog2(`MB_REG_WORDS);
  localparam int CA_W = $clog2(`MB_COILS);

  typedef enum logic [2:0] {
    S_IDLE, S_HDR, S_DISPATCH, S_WMULTI, S_RREGS, S_RCOILS, S_SEND
  } state_t;

  state_t               state;
  mb_pkg::mb_func_e     func;
  mb_pkg::mb_word_t     addr;
  mb_pkg::mb_word_t     qty;
  mb_pkg::mb_word_t     word_cnt;
  mb_pkg::mb_word_t     data_end;
  mb_pkg::mb_word_t     coil_pos;
  mb_pkg::mb_idx_t      rd_ptr;
  mb_pkg::mb_idx_t      got_idx;
  mb_pkg::mb_idx_t      wr_ptr;
  mb_pkg::mb_byte_t     hi_byte;
  mb_pkg::mb_byte_t     coil_byte;
  logic                 fetch;
  logic                 got;
  logic                 len_ok;
  logic [1:0]           phase;
  logic [RA_W-1:0]      base_idx;
  logic [`MB_COILS-1:0] coils;
  logic [`MB_COILS-1:0] coil_bit;

  // Register index wraps modulo the file depth
  assign base_idx = RA_W'(addr - cfg_map_base);
  assign coil_bit = {{(`MB_COILS-1){1'b0}}, 1'b1} << addr[CA_W-1:0];

  // Function 10 carries a byte count, then the data words from byte 7
  assign data_end = 16'd7 + {qty[14:0], 1'b0};
  assign len_ok   = (func == mb_pkg::FC_WRITE_MULTI) ?
                    ({8'h00, frame_len} == data_end + 16'd2) : (frame_len == 8'd8);

  // Frame reads, data returns one cycle later on rd_byte
  assign fetch  = (state == S_HDR && rd_ptr < 8'd6) ||
                  (state == S_WMULTI && {8'h00, rd_ptr} < data_end);
  assign rd_idx = rd_ptr;

  assign reg_re    = (state == S_RREGS) && (phase == 2'd0);
  assign reg_raddr = base_idx + word_cnt[RA_W-1:0];
  assign busy      = (state != S_IDLE);

  // Next response byte of a coil read, LSB is the lowest coil
  always_comb begin
    coil_byte = '0;
    coil_pos  = '0;
    for (int b = 0; b < 8; b++) begin
      coil_pos = addr + word_cnt + 16'(b);
      if (word_cnt + 16'(b) < qty && coil_pos < `MB_COILS) begin
        coil_byte[b] = coils[coil_pos[CA_W-1:0]];
      end
    end
  end

  // ==========================================================================
  // Request FSM
  // ==========================================================================
  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= S_IDLE;
      rd_ptr     <= '0;
      got        <= 1'b0;
      reg_we     <= 1'b0;
      do_we      <= 1'b0;
      body_we    <= 1'b0;
      send_start <= 1'b0;
      coils      <= '0;
    end else begin
      got        <= fetch;
      got_idx    <= rd_ptr;
      reg_we     <= 1'b0;
      do_we      <= 1'b0;
      body_we    <= 1'b0;
      send_start <= 1'b0;
      if (fetch) begin
        rd_ptr <= rd_ptr + 8'd1;
      end
      case (state)
        S_IDLE: begin
          if (frame_ok) begin
            rd_ptr <= '0;
            state  <= S_HDR;
          end
        end
        S_HDR: begin
          // Header bytes 0..5 double as the echo part of the response
          if (got) begin
            body_we   <= 1'b1;
            body_idx  <= got_idx;
            body_byte <= rd_byte;
            case (got_idx)
              8'd1: func <= mb_pkg::mb_func_e'(rd_byte);
              8'd2: addr[15:8] <= rd_byte;
              8'd3: addr[7:0] <= rd_byte;
              8'd4: qty[15:8] <= rd_byte;
              8'd5: begin
                qty[7:0] <= rd_byte;
                state    <= S_DISPATCH;
              end
              default: ;
            endcase
          end
        end
        S_DISPATCH: begin
          // Unknown or malformed requests fall back to idle without a reply
          state    <= S_IDLE;
          word_cnt <= '0;
          phase    <= 2'd0;
          wr_ptr   <= 8'd3;
          if (len_ok) begin
            case (func)
              mb_pkg::FC_READ_COILS: begin
                body_we   <= 1'b1;
                body_idx  <= 8'd2;
                body_byte <= mb_pkg::mb_byte_t'((qty + 16'd7) >> 3);
                if (qty != '0) begin
                  state <= S_RCOILS;
                end
              end
              mb_pkg::FC_READ_HOLD: begin
                body_we   <= 1'b1;
                body_idx  <= 8'd2;
                body_byte <= {qty[6:0], 1'b0};
                if (qty != '0) begin
                  state <= S_RREGS;
                end
              end
              mb_pkg::FC_WRITE_COIL: begin
                do_we    <= 1'b1;
                do_wmask <= coil_bit;
                if (qty == 16'hFF00) begin
                  do_wdata <= coil_bit;
                  coils    <= coils | coil_bit;
                end else begin
                  do_wdata <= '0;
                  coils    <= coils & ~coil_bit;
                end
                body_len   <= 8'd6;
                send_start <= 1'b1;
                state      <= S_SEND;
              end
              mb_pkg::FC_WRITE_REG: begin
                reg_we     <= 1'b1;
                reg_waddr  <= base_idx;
                reg_wdata  <= qty;
                body_len   <= 8'd6;
                send_start <= 1'b1;
                state      <= S_SEND;
              end
              mb_pkg::FC_WRITE_MULTI: begin
                rd_ptr <= 8'd7;
                state  <= S_WMULTI;
              end
              default: ;
            endcase
          end
        end
        S_WMULTI: begin
          // Odd offsets carry the high byte of each word
          if (got) begin
            if (got_idx[0]) begin
              hi_byte <= rd_byte;
            end else begin
              reg_we    <= 1'b1;
              reg_waddr <= base_idx + word_cnt[RA_W-1:0];
              reg_wdata <= {hi_byte, rd_byte};
              word_cnt  <= word_cnt + 16'd1;
            end
          end
          if (word_cnt == qty) begin
            body_len   <= 8'd6;
            send_start <= 1'b1;
            state      <= S_SEND;
          end
        end
        S_RREGS: begin
          // Read strobe, then high byte, then low byte of each word
          case (phase)
            2'd0: phase <= 2'd1;
            2'd1: begin
              body_we   <= 1'b1;
              body_idx  <= wr_ptr;
              body_byte <= reg_rdata[15:8];
              wr_ptr    <= wr_ptr + 8'd1;
              phase     <= 2'd2;
            end
            default: begin
              body_we   <= 1'b1;
              body_idx  <= wr_ptr;
              body_byte <= reg_rdata[7:0];
              wr_ptr    <= wr_ptr + 8'd1;
              phase     <= 2'd0;
              word_cnt  <= word_cnt + 16'd1;
              if (word_cnt + 16'd1 == qty) begin
                body_len   <= wr_ptr + 8'd1;
                send_start <= 1'b1;
                state      <= S_SEND;
              end
            end
          endcase
        end
        S_RCOILS: begin
          // word_cnt counts coils here, eight per body byte
          body_we   <= 1'b1;
          body_idx  <= wr_ptr;
          body_byte <= coil_byte;
          wr_ptr    <= wr_ptr + 8'd1;
          word_cnt  <= word_cnt + 16'd8;
          if (word_cnt + 16'd8 >= qty) begin
            body_len   <= wr_ptr + 8'd1;
            send_start <= 1'b1;
            state      <= S_SEND;
          end
        end
        default: begin
          if (send_done) begin
            state <= S_IDLE;
          end
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== src/response_sender.sv ====
// Response sender
// Buffers the response body and streams it on a valid/ready byte port,
// then appends the CRC low byte first

`default_nettype none
`timescale 1ns/1ns

`include "mb_macros.svh"

module response_sender (
  input  logic             clk,
  input  logic             rst,
  input  logic             body_we,
  input  mb_pkg::mb_idx_t  body_idx,
  input  mb_pkg::mb_byte_t body_byte,
  input  mb_pkg::mb_idx_t  body_len,
  input  logic             send_start,
  output mb_pkg::mb_byte_t tx_b,
  output logic             tx_b_v,
  input  logic             tx_b_rdy,
  output logic             send_done
);

  typedef enum logic [2:0] {S_IDLE, S_BODY, S_CRC_LO, S_CRC_HI, S_CRC_END} state_t;

  state_t           state;
  mb_pkg::mb_byte_t body_buf [`MB_BUF_BYTES];
  mb_pkg::mb_idx_t  len;
  mb_pkg::mb_idx_t  idx;
  mb_pkg::mb_word_t crc;
  logic             body_xfer;

  // Only body bytes are folded, and only once they are accepted
  assign body_xfer = tx_b_v && tx_b_rdy && (state == S_BODY);

  crc16_modbus u_crc (
    .clk        (clk),
    .rst        (rst),
    .clr        (send_start && state == S_IDLE),
    .data_in    (tx_b),
    .data_valid (body_xfer),
    .crc        (crc)
  );

  always_ff @(posedge clk) begin
    if (body_we) begin
      body_buf[body_idx] <= body_byte;
    end
  end

  // ==========================================================================
  // Output stream, tx_b holds until its handshake
  // ==========================================================================
  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= S_IDLE;
      tx_b_v    <= 1'b0;
      send_done <= 1'b0;
    end else begin
      send_done <= 1'b0;
      case (state)
        S_IDLE: begin
          if (send_start) begin
            len   <= body_len;
            idx   <= '0;
            state <= S_BODY;
          end
        end
        S_BODY: begin
          if (!tx_b_v || tx_b_rdy) begin
            if (idx != len) begin
              tx_b   <= body_buf[idx];
              tx_b_v <= 1'b1;
              idx    <= idx + 8'd1;
            end else begin
              tx_b_v <= 1'b0;
              state  <= S_CRC_LO;
            end
          end
        end
        S_CRC_LO: begin
          // CRC has taken the last body byte by now
          tx_b   <= crc[7:0];
          tx_b_v <= 1'b1;
          state  <= S_CRC_HI;
        end
        S_CRC_HI: begin
          if (tx_b_rdy) begin
            tx_b  <= crc[15:8];
            state <= S_CRC_END;
          end
        end
        default: begin
          if (tx_b_rdy) begin
            tx_b_v    <= 1'b0;
            send_done <= 1'b1;
            state     <= S_IDLE;
          end
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== tests/tb_modbus_slave.sv ====
// Modbus RTU slave testbench
// Sends request frames, collects responses under random back-pressure
// and checks them against the protocol rules and a reference CRC

`default_nettype none
`timescale 1ns/1ns

`include "mb_macros.svh"

module tb_modbus_slave;

  localparam logic [7:0] DEV = 8'h11;

  logic                 clk;
  logic                 rst;
  logic [15:0]          cfg_map_base;
  logic                 frame_start;
  logic                 frame_end;
  logic [7:0]           rx_b;
  logic                 rx_b_v;
  logic [7:0]           tx_b;
  logic                 tx_b_v;
  logic                 tx_b_rdy = 1'b0;
  logic [`MB_COILS-1:0] do_wdata;
  logic [`MB_COILS-1:0] do_wmask;
  logic                 do_we;
  logic                 stat_crc_err;

  logic [7:0]           req_q[$];
  logic [7:0]           exp_q[$];
  logic [7:0]           rsp_q[$];
  logic [15:0]          words [4];
  logic [`MB_COILS-1:0] last_wmask;
  logic [`MB_COILS-1:0] last_wdata;
  int                   we_cnt = 0;
  int                   we_before;
  int                   errors;
  int                   checks;

  modbus_slave_top uut (
    .clk          (clk),
    .rst          (rst),
    .cfg_map_base (cfg_map_base),
    .frame_start  (frame_start),
    .frame_end    (frame_end),
    .rx_b         (rx_b),
    .rx_b_v       (rx_b_v),
    .tx_b         (tx_b),
    .tx_b_v       (tx_b_v),
    .tx_b_rdy     (tx_b_rdy),
    .do_wdata     (do_wdata),
    .do_wmask     (do_wmask),
    .do_we        (do_we),
    .stat_crc_err (stat_crc_err)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Random back-pressure with ready about three cycles in four
  initial begin
    void'($urandom(32'hc206_856f));
    forever begin
      @(posedge clk);
      tx_b_rdy <= ($urandom % 4) != 0;
    end
  end

  // Response bytes and coil writes as the DUT presents them
  always @(posedge clk) begin
    if (!rst && tx_b_v && tx_b_rdy) begin
      rsp_q.push_back(tx_b);
    end
    if (!rst && do_we) begin
      we_cnt     = we_cnt + 1;
      last_wmask = do_wmask;
      last_wdata = do_wdata;
    end
  end

  // Reference Modbus CRC-16 with reflected bits and the LSB of each byte first
  function automatic logic [15:0] ref_crc(input logic [7:0] q[$]);
    logic [15:0] c;
    c = `MB_CRC_INIT;
    foreach (q[i]) begin
      c = c ^ {8'h00, q[i]};
      repeat (8) begin
        if (c[0]) begin
          c = (c >> 1) ^ `MB_CRC_POLY;
        end else begin
          c = c >> 1;
        end
      end
    end
    return c;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] want);
    checks++;
    assert (got == want) else begin
      $display("FAILED %s got %0h expected %0h", name, got, want);
      errors++;
    end
  endtask

  // Address, function and the 16-bit address and value fields
  task automatic make_request(input logic [7:0] fc, input logic [15:0] addr,
                              input logic [15:0] val);
    req_q.delete();
    req_q.push_back(DEV);
    req_q.push_back(fc);
    req_q.push_back(addr[15:8]);
    req_q.push_back(addr[7:0]);
    req_q.push_back(val[15:8]);
    req_q.push_back(val[7:0]);
  endtask

  task automatic seal_request;
    logic [15:0] c;
    c = ref_crc(req_q);
    req_q.push_back(c[7:0]);
    req_q.push_back(c[15:8]);
  endtask

  task automatic seal_expected;
    logic [15:0] c;
    c = ref_crc(exp_q);
    exp_q.push_back(c[7:0]);
    exp_q.push_back(c[15:8]);
  endtask

  // Write responses repeat the first six request bytes
  task automatic echo_expected;
    exp_q.delete();
    for (int i = 0; i < 6; i++) begin
      exp_q.push_back(req_q[i]);
    end
    seal_expected();
  endtask

  task automatic send_frame;
    @(posedge clk);
    frame_start <= 1'b1;
    @(posedge clk);
    frame_start <= 1'b0;
    for (int i = 0; i < req_q.size(); i++) begin
      rx_b   <= req_q[i];
      rx_b_v <= 1'b1;
      @(posedge clk);
    end
    rx_b_v    <= 1'b0;
    frame_end <= 1'b1;
    @(posedge clk);
    frame_end <= 1'b0;
  endtask

  task automatic wait_response(input int n);
    int cycles;
    cycles = 0;
    while (rsp_q.size() < n && cycles < 2000) begin
      @(negedge clk);
      cycles++;
    end
    if (rsp_q.size() < n) begin
      $display("Timed out waiting for a response, %0d of %0d bytes seen", rsp_q.size(), n);
      errors++;
    end
    // Idle gap that also catches stray bytes after the end
    repeat (8) @(negedge clk);
  endtask

  task automatic check_response(input string name);
    check_value({name, " response length"}, rsp_q.size(), exp_q.size());
    for (int i = 0; i < exp_q.size() && i < rsp_q.size(); i++) begin
      checks++;
      assert (rsp_q[i] == exp_q[i]) else begin
        $display("FAILED tx_b %s byte %0d got %02h expected %02h",
                 name, i, rsp_q[i], exp_q[i]);
        errors++;
      end
    end
  endtask

  task automatic exchange(input string name);
    rsp_q.delete();
    send_frame();
    wait_response(exp_q.size());
    check_response(name);
  endtask

  task automatic expect_silence(input int cycles);
    int n;
    n = 0;
    while (n < cycles) begin
      @(negedge clk);
      check_value("tx_b_v", 32'(tx_b_v), 32'h0);
      n++;
    end
  endtask

  // ==========================================================================
  // Test sequence
  // ==========================================================================
  initial begin
    errors = 0;
    checks = 0;
    words[0] = 16'h1234;
    words[1] = 16'h5678;
    words[2] = 16'h9ABC;
    words[3] = 16'hDEF0;
    rst          <= 1'b1;
    cfg_map_base <= 16'h0100;
    frame_start  <= 1'b0;
    frame_end    <= 1'b0;
    rx_b         <= 8'h00;
    rx_b_v       <= 1'b0;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_value("tx_b_v", 32'(tx_b_v), 32'h0);
    check_value("do_we", 32'(do_we), 32'h0);
    check_value("stat_crc_err", 32'(stat_crc_err), 32'h0);

    // Single register write and its read back
    make_request(8'h06, 16'h0105, 16'hA55A);
    seal_request();
    echo_expected();
    exchange("write register");
    make_request(8'h03, 16'h0105, 16'h0001);
    seal_request();
    exp_q = '{DEV, 8'h03, 8'h02, 8'hA5, 8'h5A};
    seal_expected();
    exchange("read register");

    // Four words in one request and a block read of the same range
    make_request(8'h10, 16'h0110, 16'h0004);
    req_q.push_back(8'h08);
    foreach (words[i]) begin
      req_q.push_back(words[i][15:8]);
      req_q.push_back(words[i][7:0]);
    end
    seal_request();
    echo_expected();
    exchange("write multiple");
    make_request(8'h03, 16'h0110, 16'h0004);
    seal_request();
    exp_q = '{DEV, 8'h03, 8'h08};
    foreach (words[i]) begin
      exp_q.push_back(words[i][15:8]);
      exp_q.push_back(words[i][7:0]);
    end
    seal_expected();
    exchange("read block");

    // Coil 7 on and a read of 16 coils from 0
    we_before = we_cnt;
    make_request(8'h05, 16'h0007, 16'hFF00);
    seal_request();
    echo_expected();
    exchange("write coil");
    check_value("do_we pulses", we_cnt - we_before, 32'h1);
    check_value("do_wmask", last_wmask, 32'h0000_0080);
    check_value("do_wdata", last_wdata, 32'h0000_0080);
    make_request(8'h01, 16'h0000, 16'h0010);
    seal_request();
    exp_q = '{DEV, 8'h01, 8'h02, 8'h80, 8'h00};
    seal_expected();
    exchange("read coils");

    // Corrupted CRC gets no answer and sets the sticky status
    make_request(8'h03, 16'h0105, 16'h0001);
    seal_request();
    req_q[7] = req_q[7] ^ 8'h40;
    rsp_q.delete();
    send_frame();
    expect_silence(200);
    check_value("stat_crc_err", 32'(stat_crc_err), 32'h1);
    make_request(8'h03, 16'h0105, 16'h0001);
    seal_request();
    exp_q = '{DEV, 8'h03, 8'h02, 8'hA5, 8'h5A};
    seal_expected();
    exchange("read after bad frame");
    check_value("stat_crc_err", 32'(stat_crc_err), 32'h1);

    // Function 04 is not supported and is dropped silently
    we_before = we_cnt;
    make_request(8'h04, 16'h0000, 16'h0002);
    seal_request();
    rsp_q.delete();
    send_frame();
    expect_silence(200);
    check_value("do_we pulses", we_cnt - we_before, 32'h0);
    check_value("response bytes to function 04", rsp_q.size(), 32'h0);

    $display("Run complete: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+include
src/mb_pkg.sv
src/crc16_modbus.sv
src/frame_collector.sv
src/holding_regs.sv
src/request_executor.sv
src/response_sender.sv
src/modbus_slave_top.sv
tests/tb_modbus_slave.sv
